// File: hdl/ex_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Execute stage configuration
// Data word width, register address width and multiply-high latency
////////////////////////////////////////////////////////////////////////////

`ifndef EX_CFG_SVH
`define EX_CFG_SVH

`default_nettype none

// Width of one data word
`define EX_XLEN 32
// Register file address width, 32 GPRs plus the upper bank
`define EX_RADDR_W 6
// Cycles spent by MULH and MULHU
`define EX_MULH_CYCLES 2

`default_nettype wire

`endif

// File: hdl/ex_ops_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Operation types for the execute stage functional units
// Opcode encodings, operand word views and the vector mode
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

package ex_ops_pkg;

  // Shared opcode space, each unit acts only on its own codes
  typedef enum logic [4:0] {
    ALU_ADD   = 5'h00,
    ALU_SUB   = 5'h01,
    ALU_AND   = 5'h02,
    ALU_OR    = 5'h03,
    ALU_XOR   = 5'h04,
    ALU_SLTS  = 5'h05,
    ALU_SLTU  = 5'h06,
    // Branch comparisons
    ALU_EQ    = 5'h08,
    ALU_NE    = 5'h09,
    ALU_LTS   = 5'h0a,
    ALU_LTU   = 5'h0b,
    ALU_GES   = 5'h0c,
    ALU_GEU   = 5'h0d,
    // Multiplier operations
    MUL_MUL   = 5'h10,
    MUL_MULH  = 5'h11,
    MUL_MULHU = 5'h12
  } ex_op_e;

  // One operand word, seen whole or as two halfwords
  typedef union packed {
    logic [`EX_XLEN-1:0] word;
    struct packed {
      logic [`EX_XLEN/2-1:0] hi;
      logic [`EX_XLEN/2-1:0] lo;
    } half;
  } operand_u;

  typedef enum logic {
    VEC_WORD = 1'b0,
    VEC_HALF = 1'b1
  } vec_mode_e;

endpackage

`default_nettype wire

// File: hdl/ex_pipe_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline-level types of the execute stage
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

package ex_pipe_pkg;

  // Register file address, upper bit selects the second bank
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  // Source of the forwarding write port
  typedef enum logic [1:0] {
    FW_NONE = 2'b00,
    FW_ALU  = 2'b01,
    FW_MULT = 2'b10,
    FW_CSR  = 2'b11
  } fw_src_e;

endpackage

`default_nettype wire

// File: hdl/ex_issue_if.sv
////////////////////////////////////////////////////////////////////////////
// Issue bus between the stage and one functional unit
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

interface ex_issue_if;
  import ex_ops_pkg::*;

  // Issue side
  logic                en;
  ex_op_e              op;
  operand_u            operand_a;
  operand_u            operand_b;
  // Return side
  logic [`EX_XLEN-1:0] result;

  // Stage drives the operation, keeps it stable while the unit is busy
  modport stage (output en, op, operand_a, operand_b, input result);

  // Unit returns its result
  modport unit (input en, op, operand_a, operand_b, output result);

endinterface

`default_nettype wire

// File: hdl/ex_alu.sv
////////////////////////////////////////////////////////////////////////////
// Integer ALU
// Single-cycle logic, add/sub, set and branch compare operations
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

module ex_alu (
  ex_issue_if.unit              alu_bus,
  input  ex_ops_pkg::vec_mode_e vec_mode_i,
  output logic                  cmp_result_o
);
  import ex_ops_pkg::*;

  operand_u            sum;
  logic [`EX_XLEN-1:0] diff;
  logic                lt_s;
  logic                lt_u;
  logic                eq;
  logic                cmp;
  logic [`EX_XLEN-1:0] res;

  // Adder, halfword mode keeps the two lanes apart
  always_comb begin
    if (vec_mode_i == VEC_HALF) begin
      sum.half.lo = alu_bus.operand_a.half.lo + alu_bus.operand_b.half.lo;
      sum.half.hi = alu_bus.operand_a.half.hi + alu_bus.operand_b.half.hi;
    end else begin
      sum.word = alu_bus.operand_a.word + alu_bus.operand_b.word;
    end
  end

  assign diff = alu_bus.operand_a.word - alu_bus.operand_b.word;

  // Comparator
  assign eq   = (alu_bus.operand_a.word == alu_bus.operand_b.word);
  assign lt_s = ($signed(alu_bus.operand_a.word) < $signed(alu_bus.operand_b.word));
  assign lt_u = (alu_bus.operand_a.word < alu_bus.operand_b.word);

  always_comb begin
    unique case (alu_bus.op)
      ALU_SLTS, ALU_LTS: cmp = lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_GES:           cmp = ~lt_s;
      ALU_GEU:           cmp = ~lt_u;
      ALU_EQ:            cmp = eq;
      ALU_NE:            cmp = ~eq;
      default:           cmp = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    unique case (alu_bus.op)
      ALU_ADD: res = sum.word;
      ALU_SUB: res = diff;
      ALU_AND: res = alu_bus.operand_a.word & alu_bus.operand_b.word;
      ALU_OR:  res = alu_bus.operand_a.word | alu_bus.operand_b.word;
      ALU_XOR: res = alu_bus.operand_a.word ^ alu_bus.operand_b.word;
      ALU_SLTS, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU:
        res = {{(`EX_XLEN-1){1'b0}}, cmp};
      // Multiplier codes are not ours
      default: res = '0;
    endcase
  end

  // Idle ALU presents zero
  assign alu_bus.result = alu_bus.en ? res : '0;
  assign cmp_result_o   = cmp;

endmodule

`default_nettype wire

// File: hdl/ex_mult.sv
////////////////////////////////////////////////////////////////////////////
// Integer multiplier
// Low word in one cycle, signed/unsigned high word in two
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

module ex_mult (
  input  logic     clk,
  input  logic     rst_n,
  ex_issue_if.unit mult_bus,
  input  logic     ex_ready_i,
  output logic     ready_o,
  output logic     multicycle_o
);
  import ex_ops_pkg::*;

  localparam int XW = `EX_XLEN;

  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_HIGH = 1'b1
  } mult_state_e;

  mult_state_e         state_q;
  mult_state_e         state_d;
  logic                op_signed;
  logic                mulh_start;
  logic [2*XW+1:0]     prod_full;
  logic [2*XW-1:0]     prod_q;

  // One 33x33 signed multiplier serves all three operations
  assign op_signed = (mult_bus.op == MUL_MULH);
  assign prod_full = $signed({op_signed & mult_bus.operand_a.word[XW-1],
                              mult_bus.operand_a.word})
                   * $signed({op_signed & mult_bus.operand_b.word[XW-1],
                              mult_bus.operand_b.word});

  // High-word request seen while idle
  assign mulh_start = mult_bus.en && (state_q == MULT_IDLE)
                      && (mult_bus.op inside {MUL_MULH, MUL_MULHU});

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: if (mulh_start) state_d = MULT_HIGH;
      // Leave once the stage has taken the upper word
      MULT_HIGH: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Product held for the second cycle
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      prod_q <= prod_full[2*XW-1:0];
    end
  end

  assign ready_o         = ~mulh_start;
  assign multicycle_o    = (state_q == MULT_HIGH);
  assign mult_bus.result = (state_q == MULT_HIGH) ? prod_q[2*XW-1:XW] : prod_full[XW-1:0];

endmodule

`default_nettype wire

// File: hdl/ex_wb_reg.sv
////////////////////////////////////////////////////////////////////////////
// EX/WB register
// Holds the pending LSU write-back enable and address
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ex_wb_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  regfile_we_i,
  input  logic                  lsu_err_i,
  input  ex_pipe_pkg::reg_addr_t regfile_waddr_i,
  output logic                  regfile_we_wb_o,
  output ex_pipe_pkg::reg_addr_t regfile_waddr_wb_o
);

  logic load_we;

  // Faulting loads never reach the register file
  assign load_we = regfile_we_i & ~lsu_err_i;

  // Enable, valid implies WB is ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_i) begin
      regfile_we_wb_o <= load_we;
    end else if (wb_ready_i) begin
      // No new instruction, flush the old one
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage
// ALU, multiplier, forwarding port, EX/WB register and stall control
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // ALU
  input  ex_ops_pkg::ex_op_e     alu_operator_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_c_i,
  input  logic                   alu_en_i,
  input  ex_ops_pkg::vec_mode_e  alu_vec_mode_i,
  // Multiplier
  input  ex_ops_pkg::ex_op_e     mult_operator_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_b_i,
  input  logic                   mult_en_i,
  output logic                   mult_multicycle_o,
  // LSU
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,
  // From decode
  input  logic                   branch_in_ex_i,
  input  ex_pipe_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic                   regfile_alu_we_i,
  input  logic                   regfile_we_i,
  input  ex_pipe_pkg::reg_addr_t regfile_waddr_i,
  // CSR
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  // Write-back port
  output ex_pipe_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic                   regfile_we_wb_o,
  output logic [`EX_XLEN-1:0]    regfile_wdata_wb_o,
  // Forwarding port
  output ex_pipe_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic                   regfile_alu_we_fw_o,
  output logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o,
  // Branch
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,
  // Stall control
  output logic                   ex_ready_o,
  output logic                   ex_valid_o,
  input  logic                   wb_ready_i
);
  import ex_pipe_pkg::*;

  ex_issue_if alu_bus ();
  ex_issue_if mult_bus ();

  fw_src_e fw_src;
  logic    alu_cmp_result;
  logic    mult_ready;
  logic    units_ready;

  assign alu_bus.en         = alu_en_i;
  assign alu_bus.op         = alu_operator_i;
  assign alu_bus.operand_a  = alu_operand_a_i;
  assign alu_bus.operand_b  = alu_operand_b_i;

  assign mult_bus.en        = mult_en_i;
  assign mult_bus.op        = mult_operator_i;
  assign mult_bus.operand_a = mult_operand_a_i;
  assign mult_bus.operand_b = mult_operand_b_i;

  ex_alu alu_i (
    .alu_bus      (alu_bus.unit),
    .vec_mode_i   (alu_vec_mode_i),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_bus     (mult_bus.unit),
    .ex_ready_i   (ex_ready_o),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding write port
  ////////////////////////////////////////////////////////////////////////////

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i)   fw_src = FW_CSR;
    else if (mult_en_i) fw_src = FW_MULT;
    else if (alu_en_i)  fw_src = FW_ALU;
    else                fw_src = FW_NONE;
  end

  always_comb begin
    case (fw_src)
      FW_CSR:  regfile_alu_wdata_fw_o = csr_rdata_i;
      FW_MULT: regfile_alu_wdata_fw_o = mult_bus.result;
      FW_ALU:  regfile_alu_wdata_fw_o = alu_bus.result;
      default: regfile_alu_wdata_fw_o = '0;
    endcase
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Branch outcome resolved here, target computed in decode
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////////////////////////////////////////
  // Load write-back and stall control
  ////////////////////////////////////////////////////////////////////////////

  ex_wb_reg wb_reg_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .lsu_err_i          (lsu_err_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o)
  );

  // Load data arrives in WB, just passed along
  assign regfile_wdata_wb_o = lsu_rdata_i;

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Branches finish here, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

// File: bench/ex_stage_chk.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage protocol checker, bound into every ex_stage
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ex_stage_chk (
  input logic clk,
  input logic rst_n,
  input logic ex_valid_i,
  input logic wb_ready_i,
  input logic we_wb_i,
  input logic multicycle_i,
  input logic mult_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions
  int fail_count = 0;

  // Valid instruction only leaves when WB can take it
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else begin
      $error("ex_valid_o high while wb_ready_i is low");
      fail_count++;
    end

  // Nothing pending in WB right after reset
  wb_clear_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !we_wb_i)
    else begin
      $error("regfile_we_wb_o high in the cycle after reset");
      fail_count++;
    end

  // Upper word is presented with the multiplier ready
  multicycle_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_i |-> mult_ready_i)
    else begin
      $error("mult_multicycle_o high while the multiplier stalls");
      fail_count++;
    end

endmodule

bind ex_stage ex_stage_chk chk_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .ex_valid_i   (ex_valid_o),
  .wb_ready_i   (wb_ready_i),
  .we_wb_i      (regfile_we_wb_o),
  .multicycle_i (mult_multicycle_o),
  .mult_ready_i (mult_ready)
);

`default_nettype wire

// File: bench/ex_stage_tb.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage testbench
// File-driven vectors over ALU, multiplier, forwarding and write-back
////////////////////////////////////////////////////////////////////////////

`include "ex_cfg.svh"

`default_nettype none

module ex_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ex_ops_pkg::*;
  import ex_pipe_pkg::*;

  localparam int    MAX_TESTS = 64;
  localparam int    PERIOD    = 20;
  localparam string DATA_FILE = "bench/ex_stage_input.dat";

  logic                clk = 1'b0;
  logic                rst_n;
  // Operator and operands are shared by ALU and multiplier
  ex_op_e              op;
  vec_mode_e           vec_mode;
  logic [`EX_XLEN-1:0] operand_a;
  logic [`EX_XLEN-1:0] operand_b;
  // Operand C also feeds CSR and load data
  logic [`EX_XLEN-1:0] operand_c;
  logic                alu_en;
  logic                mult_en;
  logic                csr_access;
  logic                lsu_en;
  logic                lsu_ready_ex;
  logic                lsu_err;
  logic                branch_in_ex;
  logic                regfile_alu_we;
  logic                regfile_we;
  logic                wb_ready;
  reg_addr_t           waddr;
  // DUT outputs
  logic                mult_multicycle;
  reg_addr_t           regfile_waddr_wb;
  logic                regfile_we_wb;
  logic [`EX_XLEN-1:0] regfile_wdata_wb;
  reg_addr_t           regfile_alu_waddr_fw;
  logic                regfile_alu_we_fw;
  logic [`EX_XLEN-1:0] regfile_alu_wdata_fw;
  logic [`EX_XLEN-1:0] jump_target;
  logic                branch_decision;
  logic                ex_ready;
  logic                ex_valid;

  // Test table
  logic [159:0]        t_name [MAX_TESTS];
  logic [3:0]          t_en [MAX_TESTS];
  logic [4:0]          t_op [MAX_TESTS];
  logic [31:0]         t_a [MAX_TESTS];
  logic [31:0]         t_b [MAX_TESTS];
  logic [31:0]         t_c [MAX_TESTS];
  logic [6:0]          t_ctrl [MAX_TESTS];
  logic [5:0]          t_waddr [MAX_TESTS];
  logic [31:0]         t_fw [MAX_TESTS];
  logic                t_br [MAX_TESTS];
  logic                t_wewb [MAX_TESTS];
  logic                t_rdy [MAX_TESTS];
  logic                t_vld [MAX_TESTS];

  int                  n_tests = 0;
  int                  load_errors = 0;
  int                  test_errors;
  int                  passed = 0;
  int                  failed = 0;

  always #(PERIOD / 2) clk = ~clk;

  ex_stage ex_stage_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_operator_i         (op),
    .alu_operand_a_i        (operand_a),
    .alu_operand_b_i        (operand_b),
    .alu_operand_c_i        (operand_c),
    .alu_en_i               (alu_en),
    .alu_vec_mode_i         (vec_mode),
    .mult_operator_i        (op),
    .mult_operand_a_i       (operand_a),
    .mult_operand_b_i       (operand_b),
    .mult_en_i              (mult_en),
    .mult_multicycle_o      (mult_multicycle),
    .lsu_en_i               (lsu_en),
    .lsu_rdata_i            (operand_c),
    .lsu_ready_ex_i         (lsu_ready_ex),
    .lsu_err_i              (lsu_err),
    .branch_in_ex_i         (branch_in_ex),
    .regfile_alu_waddr_i    (waddr),
    .regfile_alu_we_i       (regfile_alu_we),
    .regfile_we_i           (regfile_we),
    .regfile_waddr_i        (waddr),
    .csr_access_i           (csr_access),
    .csr_rdata_i            (operand_c),
    .regfile_waddr_wb_o     (regfile_waddr_wb),
    .regfile_we_wb_o        (regfile_we_wb),
    .regfile_wdata_wb_o     (regfile_wdata_wb),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw),
    .jump_target_o          (jump_target),
    .branch_decision_o      (branch_decision),
    .ex_ready_o             (ex_ready),
    .ex_valid_o             (ex_valid),
    .wb_ready_i             (wb_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int           fd;
    int           n;
    string        line;
    logic [159:0] name_raw;
    logic [3:0]   en;
    logic [4:0]   op_v;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  c;
    logic [6:0]   ctrl;
    logic [5:0]   waddr_v;
    logic [31:0]  fw;
    logic         br;
    logic         wewb;
    logic         rdy;
    logic         vld;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", DATA_FILE);
      load_errors++;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        n = $fgets(line, fd);
        // Skip blank and comment lines
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                      name_raw, en, op_v, a, b, c, ctrl, waddr_v,
                      fw, br, wewb, rdy, vld);
          if (n == 13) begin
            t_name[n_tests]  = name_raw;
            t_en[n_tests]    = en;
            t_op[n_tests]    = op_v;
            t_a[n_tests]     = a;
            t_b[n_tests]     = b;
            t_c[n_tests]     = c;
            t_ctrl[n_tests]  = ctrl;
            t_waddr[n_tests] = waddr_v;
            t_fw[n_tests]    = fw;
            t_br[n_tests]    = br;
            t_wewb[n_tests]  = wewb;
            t_rdy[n_tests]   = rdy;
            t_vld[n_tests]   = vld;
            n_tests++;
          end else begin
            $display("Malformed line in the stimulus file: %s", line);
            load_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////

  // Quiet stage with WB and LSU ready so the WB register flushes
  task automatic drive_idle();
    alu_en         <= 1'b0;
    mult_en        <= 1'b0;
    csr_access     <= 1'b0;
    lsu_en         <= 1'b0;
    regfile_alu_we <= 1'b0;
    regfile_we     <= 1'b0;
    lsu_err        <= 1'b0;
    wb_ready       <= 1'b1;
    lsu_ready_ex   <= 1'b1;
    branch_in_ex   <= 1'b0;
  endtask

  task automatic drive_test(input int i);
    op             <= ex_op_e'(t_op[i]);
    operand_a      <= t_a[i];
    operand_b      <= t_b[i];
    operand_c      <= t_c[i];
    waddr          <= t_waddr[i];
    alu_en         <= t_en[i][0];
    mult_en        <= t_en[i][1];
    csr_access     <= t_en[i][2];
    lsu_en         <= t_en[i][3];
    vec_mode       <= vec_mode_e'(t_ctrl[i][0]);
    regfile_alu_we <= t_ctrl[i][1];
    regfile_we     <= t_ctrl[i][2];
    lsu_err        <= t_ctrl[i][3];
    wb_ready       <= t_ctrl[i][4];
    branch_in_ex   <= t_ctrl[i][5];
    lsu_ready_ex   <= t_ctrl[i][6];
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic run_test(input int i);
    string name;
    logic  is_mulh;
    int    cycles;
    name        = $sformatf("%0s", t_name[i]);
    is_mulh     = t_en[i][1] && (t_op[i] == MUL_MULH || t_op[i] == MUL_MULHU);
    test_errors = 0;
    @(posedge clk);
    drive_test(i);
    @(negedge clk);
    cycles = 1;
    if (is_mulh) begin
      // Stage stalls while the product is registered
      check_value(name, "ready first cycle", 32'd0, 32'(ex_ready));
      check_value(name, "valid first cycle", 32'd0, 32'(ex_valid));
      while (!ex_ready && cycles <= `EX_MULH_CYCLES) begin
        @(negedge clk);
        cycles++;
      end
      check_value(name, "cycles", 32'(`EX_MULH_CYCLES), 32'(cycles));
    end
    check_value(name, "fw data", t_fw[i], regfile_alu_wdata_fw);
    check_value(name, "fw addr", 32'(t_waddr[i]), 32'(regfile_alu_waddr_fw));
    check_value(name, "fw we", 32'(t_ctrl[i][1]), 32'(regfile_alu_we_fw));
    check_value(name, "branch", 32'(t_br[i]), 32'(branch_decision));
    check_value(name, "jump target", t_c[i], jump_target);
    check_value(name, "wb data", t_c[i], regfile_wdata_wb);
    check_value(name, "ready", 32'(t_rdy[i]), 32'(ex_ready));
    check_value(name, "valid", 32'(t_vld[i]), 32'(ex_valid));
    check_value(name, "multicycle", 32'(is_mulh), 32'(mult_multicycle));
    // WB register captures on the following edge
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_value(name, "wb we", 32'(t_wewb[i]), 32'(regfile_we_wb));
    if (t_wewb[i]) begin
      check_value(name, "wb addr", 32'(t_waddr[i]), 32'(regfile_waddr_wb));
    end
    if (test_errors == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("test %0d %s: %s", i, name, (test_errors == 0) ? "ok" : "error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     <= 1'b0;
    op        <= ALU_ADD;
    vec_mode  <= VEC_WORD;
    operand_a <= '0;
    operand_b <= '0;
    operand_c <= '0;
    waddr     <= '0;
    drive_idle();
    load_tests();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("tests %0d, passed %0d, failed %0d, load errors %0d, assertion failures %0d",
             n_tests, passed, failed, load_errors, ex_stage_i.chk_i.fail_count);
    if (failed == 0 && load_errors == 0 && n_tests > 0 &&
        ex_stage_i.chk_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Each test needs at most the multiply latency plus one idle cycle
  initial begin
    int limit_ns;
    wait (rst_n === 1'b1);
    limit_ns = n_tests * (`EX_MULH_CYCLES + 2) * PERIOD;
    #(limit_ns);
    $display("Timeout: the tests did not finish within %0d ns after reset", limit_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/ex_ops_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_issue_if.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
bench/ex_stage_chk.sv
bench/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module ex_stage_tb -o ex_stage_sim \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/ex_stage_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation finished: PASS" \
  && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }

// File: bench/ex_stage_input.dat
# name en(alu,mult,csr,lsu) op a b c ctrl(half,alu_we,we,err,wb_rdy,br,lsu_rdy) waddr
# then expected: fw_data branch we_wb ready valid
add_word      1 00 00001234 00005678 00000100 52 01 000068ac 0 0 1 1
add_carry     1 00 0000ffff 00000001 00000104 52 02 00010000 0 0 1 1
add_half_lane 1 00 0000ffff 00000001 00000108 53 03 00000000 0 0 1 1
add_half_mix  1 00 12348000 11118001 0000010c 53 04 23450001 0 0 1 1
sub           1 01 00000005 00000007 00000110 52 05 fffffffe 0 0 1 1
and           1 02 f0f0ff00 ff00f0f0 00000114 52 06 f000f000 0 0 1 1
or            1 03 f0f0ff00 0f0f00ff 00000118 52 07 ffffffff 0 0 1 1
xor           1 04 aaaa5555 ffff0000 0000011c 52 08 55555555 0 0 1 1
slts          1 05 ffffffff 00000001 00000120 52 09 00000001 1 0 1 1
sltu          1 06 ffffffff 00000001 00000124 52 0a 00000000 0 0 1 1
beq_taken     1 08 00000042 00000042 00001000 50 0b 00000001 1 0 1 1
bne_not_taken 1 09 00000042 00000042 00001040 50 0c 00000000 0 0 1 1
blt_signed    1 0a 80000000 00000001 00001080 50 0d 00000001 1 0 1 1
bltu_unsigned 1 0b 80000000 00000001 000010c0 50 0e 00000000 0 0 1 1
bge_signed    1 0c 00000003 fffffffd 00001100 50 0f 00000001 1 0 1 1
bgeu_unsigned 1 0d 00000003 fffffffd 00001140 50 10 00000000 0 0 1 1
mul_low       2 10 00012345 00001000 00000000 52 11 12345000 0 0 1 1
mul_neg       2 10 fffffffe 00000003 00000000 52 12 fffffffa 0 0 1 1
mulh_neg      2 11 fffffffe 00000003 00000000 52 13 ffffffff 0 0 1 1
mulhu_big     2 12 fffffffe 00000003 00000000 52 14 00000002 0 0 1 1
mulh_pos      2 11 40000000 00000004 00000000 52 15 00000001 0 0 1 1
csr_priority  7 00 00000001 00000002 cafef00d 52 16 cafef00d 0 0 1 1
mult_over_alu 3 10 00000003 00000005 00000000 52 17 0000000f 0 0 1 1
load_wb       8 00 00000000 00000000 0badc0de 54 2a 00000000 0 1 1 1
load_err      8 00 00000000 00000000 deadbeef 5c 15 00000000 0 0 1 1
wb_stall      1 00 00000001 00000001 00000000 42 18 00000002 0 0 0 0
branch_stall  1 08 00000005 00000005 00002000 60 19 00000001 1 0 1 0
lsu_stall     8 00 00000000 00000000 00000000 14 1a 00000000 0 0 0 0
